// ==== sources.f ====
tlu_pkg.sv
tlu_regs.sv
trigger_input_sync.sv
trigger_accept_fsm.sv
trigger_fifo.sv
tlu_controller_core.sv
tlu_controller_sva.sv
tb_tlu_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tlu_controller
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_tlu_controller.sv ====
`timescale 1ns/100ps

module tb_tlu_controller;

    localparam int clk_period      = 4;
    localparam int watchdog_cycles = 2000;
    localparam int accept_wait     = 6;  // sync stages plus edge and accept

    logic                BUS_CLK = 1'b0;
    logic                RST = 1'b1;
    logic [15:0]         BUS_ADD = '0;
    logic [7:0]          BUS_DATA_IN = '0;
    logic                BUS_RD = 1'b0;
    logic                BUS_WR = 1'b0;
    logic [7:0]          BUS_DATA_OUT;
    logic [7:0]          TRIGGER = '0;
    logic [7:0]          TRIGGER_VETO = '0;
    logic                EXT_TRIGGER_ENABLE = 1'b0;
    logic                TRIGGER_ACKNOWLEDGE = 1'b0;
    logic                TRIGGER_ACCEPTED_FLAG;
    logic                FIFO_READ = 1'b0;
    logic                FIFO_EMPTY;
    tlu_pkg::trig_word_t FIFO_DATA;

    int          errors = 0;
    int          checks = 0;
    logic [7:0]  inv_mask = '0; // idle pin levels
    int          trig_bit;
    logic [31:0] preload;

    tlu_controller_core uut (.*);

    always #(clk_period / 2) BUS_CLK = ~BUS_CLK;

    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("timeout: run still busy after %0d clock cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        BUS_ADD     = addr;
        BUS_DATA_IN = data;
        BUS_WR      = 1'b1;
        @(negedge BUS_CLK);
        BUS_WR = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        BUS_ADD = addr;
        BUS_RD  = 1'b1;
        @(negedge BUS_CLK);
        BUS_RD = 1'b0;
        data   = BUS_DATA_OUT; // registered one cycle after the strobe
    endtask

    task automatic check_reg(input string name, input logic [15:0] addr,
                             input logic [7:0] expected);
        logic [7:0] value;
        bus_read(addr, value);
        check(name, expected, value);
    endtask

    // low byte read first, it snapshots the upper bytes
    task automatic read_counter(output logic [31:0] value);
        bus_read(tlu_pkg::addr_cnt0, value[7:0]);
        bus_read(tlu_pkg::addr_cnt1, value[15:8]);
        bus_read(tlu_pkg::addr_cnt2, value[23:16]);
        bus_read(tlu_pkg::addr_cnt3, value[31:24]);
    endtask

    task automatic pulse_trigger(input string name, input int bit_idx, input logic expect_accept);
        logic seen;
        TRIGGER = inv_mask ^ (8'd1 << bit_idx);
        seen    = 1'b0;
        for (int i = 0; i < accept_wait && !seen; i++)
        begin
            @(negedge BUS_CLK);
            seen = TRIGGER_ACCEPTED_FLAG;
        end
        TRIGGER = inv_mask;
        repeat (tlu_pkg::sync_stages + 3) @(negedge BUS_CLK); // let the release pass through
        check(name, expect_accept, seen);
    endtask

    task automatic acknowledge();
        TRIGGER_ACKNOWLEDGE = 1'b1;
        @(negedge BUS_CLK);
        TRIGGER_ACKNOWLEDGE = 1'b0;
        repeat (2) @(negedge BUS_CLK);
    endtask

    task automatic pop_word(input string name, input logic [30:0] number);
        check(name, 1'b0, FIFO_EMPTY);
        check(name, {1'b1, number}, FIFO_DATA);
        FIFO_READ = 1'b1;
        @(negedge BUS_CLK);
        FIFO_READ = 1'b0;
    endtask

    task automatic test_registers();
        check_reg("version", 16'd0, tlu_pkg::version);
        for (int a = 1; a < 20; a++)
            check_reg($sformatf("reset_%0d", a), 16'(a), 8'd0);
        bus_write(tlu_pkg::addr_conf, 8'h37); // enable bit stays clear
        for (int a = 13; a < 20; a++)
            bus_write(16'(a), 8'(a * 29 + 5));
        check_reg("conf_rw", tlu_pkg::addr_conf, 8'h37);
        for (int a = 13; a < 20; a++)
            check_reg($sformatf("rw_%0d", a), 16'(a), 8'(a * 29 + 5));
        check_reg("unmapped_20", 16'd20, 8'd0);
        check_reg("unmapped_high", 16'h0123, 8'd0);
        for (int a = 13; a < 20; a++)
            bus_write(16'(a), 8'd0);
        bus_write(tlu_pkg::addr_conf, 8'd0);
        repeat (6) @(negedge BUS_CLK);
    endtask

    task automatic test_accept();
        trig_bit = int'($urandom % 8);
        inv_mask = 8'd1 << trig_bit;
        TRIGGER  = inv_mask;
        bus_write(tlu_pkg::addr_trig_inv, inv_mask);
        bus_write(tlu_pkg::addr_trig_sel, inv_mask);
        bus_write(tlu_pkg::addr_conf, 8'h08);
        repeat (6) @(negedge BUS_CLK);
        pulse_trigger("first_accept", trig_bit, 1'b1);
        check("first_word", {1'b1, 31'd0}, FIFO_DATA);
        check_reg("count_after_first", tlu_pkg::addr_cnt0, 8'd1);
        pulse_trigger("before_ack", trig_bit, 1'b0);
        acknowledge();
        pulse_trigger("second_accept", trig_bit, 1'b1);
        acknowledge();
        pop_word("word_0", 31'd0);
        pop_word("word_1", 31'd1);
        check("empty_after_pop", 1'b1, FIFO_EMPTY);
    endtask

    task automatic test_blocking();
        pulse_trigger("unselected", (trig_bit + 1) % 8, 1'b0);
        TRIGGER_VETO = 8'h81;
        bus_write(tlu_pkg::addr_veto_sel, 8'h01);
        repeat (4) @(negedge BUS_CLK);
        pulse_trigger("vetoed", trig_bit, 1'b0);
        TRIGGER_VETO = 8'h00;
        bus_write(tlu_pkg::addr_conf, 8'h00);
        pulse_trigger("disabled", trig_bit, 1'b0);
        EXT_TRIGGER_ENABLE = 1'b1;
        pulse_trigger("ext_enable", trig_bit, 1'b1);
        acknowledge();
        EXT_TRIGGER_ENABLE = 1'b0;
        pop_word("ext_word", 31'd2);
    endtask

    task automatic test_limit();
        logic [31:0] max_val;
        logic [31:0] cnt;
        preload = $urandom & 32'h7fff_fff0; // headroom so max never wraps
        max_val = preload + 32'd2;
        for (int i = 0; i < 4; i++)
            bus_write(tlu_pkg::addr_cnt0 + 16'(i), preload[8*i +: 8]);
        for (int i = 0; i < 4; i++)
            bus_write(tlu_pkg::addr_max0 + 16'(i), max_val[8*i +: 8]);
        bus_write(tlu_pkg::addr_conf, 8'h08);
        pulse_trigger("limit_first", trig_bit, 1'b1);
        acknowledge();
        pulse_trigger("limit_second", trig_bit, 1'b1);
        acknowledge();
        pulse_trigger("limit_blocked", trig_bit, 1'b0);
        read_counter(cnt);
        check("count_at_limit", max_val, cnt);
        pop_word("preload_word", preload[30:0]);
        pop_word("preload_next", preload[30:0] + 31'd1);
        for (int i = 0; i < 4; i++)
            bus_write(tlu_pkg::addr_max0 + 16'(i), 8'd0);
    endtask

    task automatic test_overflow();
        for (int i = 0; i < 10; i++)
        begin
            pulse_trigger("fill", trig_bit, 1'b1);
            acknowledge();
        end
        check_reg("lost_count", tlu_pkg::addr_lost, 8'd2);
        for (int i = 0; i < 8; i++)
            pop_word($sformatf("drain_%0d", i), preload[30:0] + 31'd2 + 31'(i));
        check("empty_after_drain", 1'b1, FIFO_EMPTY);
    endtask

    task automatic test_soft_reset();
        logic [31:0] cnt;
        pulse_trigger("pre_reset", trig_bit, 1'b1); // leaves one word and the FSM busy
        bus_write(16'd0, 8'h00);
        repeat (2) @(negedge BUS_CLK);
        read_counter(cnt);
        check("count_cleared", 32'd0, cnt);
        check_reg("lost_cleared", tlu_pkg::addr_lost, 8'd0);
        check_reg("conf_cleared", tlu_pkg::addr_conf, 8'd0);
        check("fifo_cleared", 1'b1, FIFO_EMPTY);
    endtask

    initial
    begin
        void'($urandom(32'h420d2759));
        repeat (16) @(negedge BUS_CLK);
        RST = 1'b0;
        @(negedge BUS_CLK);
        test_registers();
        test_accept();
        test_blocking();
        test_limit();
        test_overflow();
        test_soft_reset();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== tlu_controller_sva.sv ====
`timescale 1ns/100ps

module tlu_controller_sva
(
    input logic                BUS_CLK,
    input logic                RST,
    input logic                TRIGGER_ACCEPTED_FLAG,
    input logic                TRIGGER_ACKNOWLEDGE,
    input logic                FIFO_EMPTY,
    input tlu_pkg::trig_word_t FIFO_DATA
);

    logic [2:0] guard; // cycles in which another acceptance would be too early

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            guard <= 3'd0;
        else if (TRIGGER_ACCEPTED_FLAG)
            guard <= 3'd4;
        else if (TRIGGER_ACKNOWLEDGE)
            guard <= 3'd0;
        else if (guard != 3'd0)
            guard <= guard - 3'd1;
    end

    a_flag_single: assert property (@(posedge BUS_CLK) disable iff (RST)
        TRIGGER_ACCEPTED_FLAG |=> !TRIGGER_ACCEPTED_FLAG)
        else $error("accepted flag high in two consecutive cycles");

    a_head_marker: assert property (@(posedge BUS_CLK) disable iff (RST)
        !FIFO_EMPTY |-> FIFO_DATA.marker)
        else $error("FIFO head word without marker bit");

    a_accept_spacing: assert property (@(posedge BUS_CLK) disable iff (RST)
        TRIGGER_ACCEPTED_FLAG |-> (guard == 3'd0))
        else $error("second acceptance within 4 cycles and no acknowledge");

endmodule

bind tlu_controller_core tlu_controller_sva u_sva (
    .BUS_CLK(BUS_CLK),
    .RST(RST),
    .TRIGGER_ACCEPTED_FLAG(TRIGGER_ACCEPTED_FLAG),
    .TRIGGER_ACKNOWLEDGE(TRIGGER_ACKNOWLEDGE),
    .FIFO_EMPTY(FIFO_EMPTY),
    .FIFO_DATA(FIFO_DATA)
);

// ==== tlu_controller_core.sv ====
`timescale 1ns/100ps

module tlu_controller_core
(
    input  logic                                BUS_CLK,
    input  logic                                RST,
    input  logic [tlu_pkg::bus_addr_width-1:0]  BUS_ADD,
    input  logic [7:0]                          BUS_DATA_IN,
    input  logic                                BUS_RD,
    input  logic                                BUS_WR,
    output logic [7:0]                          BUS_DATA_OUT,

    input  logic [7:0]                          TRIGGER,
    input  logic [7:0]                          TRIGGER_VETO,

    input  logic                                EXT_TRIGGER_ENABLE,
    input  logic                                TRIGGER_ACKNOWLEDGE,
    output logic                                TRIGGER_ACCEPTED_FLAG,

    input  logic                                FIFO_READ,
    output logic                                FIFO_EMPTY,
    output tlu_pkg::trig_word_t                 FIFO_DATA
);

    tlu_pkg::trig_cfg_t  cfg;
    tlu_pkg::trig_word_t word;
    logic [31:0]         trig_count;
    logic                trig_enable;
    logic                soft_rst;
    logic                core_rst;
    logic                trig_level;
    logic                trig_rise;
    logic                veto;
    logic                word_write;
    logic                overflow;

    assign core_rst = RST | soft_rst; // regs handle soft reset themselves

    tlu_regs u_regs (
        .BUS_CLK(BUS_CLK), .RST(RST),
        .BUS_ADD(BUS_ADD), .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_RD(BUS_RD), .BUS_WR(BUS_WR), .BUS_DATA_OUT(BUS_DATA_OUT),
        .EXT_TRIGGER_ENABLE(EXT_TRIGGER_ENABLE),
        .accepted(TRIGGER_ACCEPTED_FLAG), .overflow(overflow),
        .cfg(cfg), .trig_enable(trig_enable), .trig_count(trig_count),
        .soft_rst(soft_rst)
    );

    trigger_input_sync u_input (
        .BUS_CLK(BUS_CLK), .RST(core_rst),
        .TRIGGER(TRIGGER), .TRIGGER_VETO(TRIGGER_VETO), .cfg(cfg),
        .trig_level(trig_level), .trig_rise(trig_rise), .veto(veto)
    );

    trigger_accept_fsm u_fsm (
        .BUS_CLK(BUS_CLK), .RST(core_rst),
        .trig_rise(trig_rise), .trig_level(trig_level), .veto(veto),
        .trig_enable(trig_enable), .trig_count(trig_count),
        .TRIGGER_ACKNOWLEDGE(TRIGGER_ACKNOWLEDGE),
        .accepted(TRIGGER_ACCEPTED_FLAG), .word_write(word_write), .word(word)
    );

    trigger_fifo u_fifo (
        .BUS_CLK(BUS_CLK), .RST(core_rst),
        .word_write(word_write), .word(word), .FIFO_READ(FIFO_READ),
        .FIFO_DATA(FIFO_DATA), .FIFO_EMPTY(FIFO_EMPTY), .overflow(overflow)
    );

endmodule

// ==== trigger_fifo.sv ====
`timescale 1ns/100ps

module trigger_fifo
(
    input  logic                 BUS_CLK,
    input  logic                 RST,
    input  logic                 word_write,
    input  tlu_pkg::trig_word_t  word,
    input  logic                 FIFO_READ,

    output tlu_pkg::trig_word_t  FIFO_DATA,
    output logic                 FIFO_EMPTY,
    output logic                 overflow
);

    localparam int aw = tlu_pkg::fifo_addr_width;

    tlu_pkg::trig_word_t mem [tlu_pkg::fifo_depth];
    logic [aw-1:0]       wr_ptr;
    logic [aw-1:0]       rd_ptr;
    logic [aw:0]         count;
    logic                full;
    logic                push;
    logic                pop;

    assign full       = count[aw]; // depth is a power of two
    assign FIFO_EMPTY = (count == '0);
    assign push       = word_write & ~full;
    assign pop        = FIFO_READ & ~FIFO_EMPTY;
    assign FIFO_DATA  = mem[rd_ptr]; // fall-through head

    always_ff @(posedge BUS_CLK)
    begin
        if (push)
            mem[wr_ptr] <= word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            overflow <= word_write & full; // word dropped
        end
    end

endmodule

// ==== trigger_accept_fsm.sv ====
`timescale 1ns/100ps

module trigger_accept_fsm
(
    input  logic                 BUS_CLK,
    input  logic                 RST,
    input  logic                 trig_rise,
    input  logic                 trig_level,
    input  logic                 veto,
    input  logic                 trig_enable,
    input  logic [31:0]          trig_count,
    input  logic                 TRIGGER_ACKNOWLEDGE,

    output logic                 accepted,
    output logic                 word_write,
    output tlu_pkg::trig_word_t  word
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,     // trigger taken, readout busy
        st_wait_release  // ack seen, trigger still high
    } state_t;

    state_t state;
    logic   take;

    assign take = (state == st_idle) && trig_rise && trig_enable && !veto;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            state    <= st_idle;
            accepted <= 1'b0;
        end
        else
        begin
            accepted <= take;
            case (state)
                st_idle:
                begin
                    if (take)
                        state <= st_wait_ack;
                end
                st_wait_ack:
                begin
                    if (TRIGGER_ACKNOWLEDGE)
                        state <= st_wait_release;
                end
                st_wait_release:
                begin
                    if (!trig_level)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // word uses the counter before its increment
    always_ff @(posedge BUS_CLK)
    begin
        if (take)
        begin
            word.marker <= 1'b1;
            word.number <= trig_count[30:0];
        end
    end

    assign word_write = accepted; // FIFO write goes with the flag

endmodule

// ==== trigger_input_sync.sv ====
`timescale 1ns/100ps

module trigger_input_sync
(
    input  logic                BUS_CLK,
    input  logic                RST,
    input  logic [7:0]          TRIGGER,
    input  logic [7:0]          TRIGGER_VETO,
    input  tlu_pkg::trig_cfg_t  cfg,

    output logic                trig_level,
    output logic                trig_rise,
    output logic                veto
);

    localparam int last = tlu_pkg::sync_stages - 1;

    logic                           trig_or;
    logic                           veto_or;
    logic [tlu_pkg::sync_stages-1:0] trig_sync;
    logic [tlu_pkg::sync_stages-1:0] veto_sync;
    logic                           trig_last;

    // per-bit polarity, then mask and merge
    assign trig_or = |((TRIGGER ^ cfg.trig_invert) & cfg.trig_select);
    assign veto_or = |(TRIGGER_VETO & cfg.veto_select);

    assign trig_level = trig_sync[last];

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            trig_sync <= '0;
            veto_sync <= '0;
            trig_last <= 1'b0;
            trig_rise <= 1'b0;
            veto      <= 1'b0;
        end
        else
        begin
            trig_sync <= {trig_sync[last-1:0], trig_or};
            veto_sync <= {veto_sync[last-1:0], veto_or};
            trig_last <= trig_level;
            trig_rise <= trig_level & ~trig_last; // one cycle per rising edge
            veto      <= veto_sync[last];         // kept aligned with trig_rise
        end
    end

endmodule

// ==== tlu_regs.sv ====
`timescale 1ns/100ps

module tlu_regs
(
    input  logic                                BUS_CLK,
    input  logic                                RST,
    input  logic [tlu_pkg::bus_addr_width-1:0]  BUS_ADD,
    input  logic [7:0]                          BUS_DATA_IN,
    input  logic                                BUS_RD,
    input  logic                                BUS_WR,
    output logic [7:0]                          BUS_DATA_OUT,

    input  logic                                EXT_TRIGGER_ENABLE,
    input  logic                                accepted,
    input  logic                                overflow,

    output tlu_pkg::trig_cfg_t                  cfg,
    output logic                                trig_enable,
    output logic [31:0]                         trig_count,
    output logic                                soft_rst
);

    logic [7:0]  regs [tlu_pkg::num_regs];
    logic [4:0]  reg_idx;
    logic        rst_all;
    logic [31:8] cnt_snap;    // upper counter bytes as seen at the last addr_cnt0 read
    logic [31:0] max_count;
    logic        limit_reached;
    logic [7:0]  lost_cnt;

    assign reg_idx = BUS_ADD[4:0];
    assign rst_all = RST | soft_rst;

    // write to address 0 resets everything one cycle later
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            soft_rst <= 1'b0;
        else
            soft_rst <= BUS_WR && (BUS_ADD == '0);
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all)
        begin
            for (int i = 0; i < int'(tlu_pkg::num_regs); i++)
                regs[i] <= 8'd0;
        end
        else if (BUS_WR && BUS_ADD != '0 && BUS_ADD < tlu_pkg::num_regs)
            regs[reg_idx] <= BUS_DATA_IN;
    end

    assign cfg.enable      = regs[tlu_pkg::addr_conf[4:0]][tlu_pkg::conf_enable_bit];
    assign cfg.trig_select = regs[tlu_pkg::addr_trig_sel[4:0]];
    assign cfg.trig_invert = regs[tlu_pkg::addr_trig_inv[4:0]];
    assign cfg.veto_select = regs[tlu_pkg::addr_veto_sel[4:0]];

    always_comb
    begin
        for (int i = 0; i < 4; i++)
            max_count[8*i +: 8] = regs[tlu_pkg::addr_max0[4:0] + 5'(i)];
    end

    // trigger counter, preload from bytes 8..10 plus the byte written to 11
    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all)
            trig_count <= 32'd0;
        else if (BUS_WR && BUS_ADD == tlu_pkg::addr_cnt3)
            trig_count <= {BUS_DATA_IN, regs[tlu_pkg::addr_cnt2[4:0]],
                           regs[tlu_pkg::addr_cnt1[4:0]], regs[tlu_pkg::addr_cnt0[4:0]]};
        else if (accepted)
            trig_count <= trig_count + 32'd1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all)
            cnt_snap <= '0;
        else if (BUS_RD && BUS_ADD == tlu_pkg::addr_cnt0)
            cnt_snap <= trig_count[31:8];
    end

    // max of zero means no limit
    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all)
            limit_reached <= 1'b0;
        else
            limit_reached <= (max_count != 32'd0) && (trig_count >= max_count);
    end

    assign trig_enable = (EXT_TRIGGER_ENABLE | cfg.enable) & ~limit_reached;

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all)
            lost_cnt <= 8'd0;
        else if (overflow && lost_cnt != 8'hff)
            lost_cnt <= lost_cnt + 8'd1; // saturates
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all)
            BUS_DATA_OUT <= 8'd0;
        else if (BUS_RD)
        begin
            case (BUS_ADD)
                '0:                      BUS_DATA_OUT <= tlu_pkg::version;
                tlu_pkg::addr_cnt0:      BUS_DATA_OUT <= trig_count[7:0];
                tlu_pkg::addr_cnt1:      BUS_DATA_OUT <= cnt_snap[15:8];
                tlu_pkg::addr_cnt2:      BUS_DATA_OUT <= cnt_snap[23:16];
                tlu_pkg::addr_cnt3:      BUS_DATA_OUT <= cnt_snap[31:24];
                tlu_pkg::addr_lost:      BUS_DATA_OUT <= lost_cnt;
                tlu_pkg::addr_conf,
                tlu_pkg::addr_trig_sel,
                tlu_pkg::addr_veto_sel,
                tlu_pkg::addr_trig_inv:  BUS_DATA_OUT <= regs[reg_idx];
                default:
                begin
                    if (BUS_ADD >= tlu_pkg::addr_max0 && BUS_ADD < tlu_pkg::num_regs)
                        BUS_DATA_OUT <= regs[reg_idx]; // max count bytes
                    else
                        BUS_DATA_OUT <= 8'd0; // unmapped
                end
            endcase
        end
    end

endmodule

// ==== tlu_pkg.sv ====
package tlu_pkg;

    localparam int bus_addr_width = 16;

    localparam logic [7:0] version = 8'd8; // read back at address 0

    // register map, byte wide
    localparam logic [bus_addr_width-1:0] addr_conf     = 16'd1;
    localparam logic [bus_addr_width-1:0] addr_cnt0     = 16'd8;  // live low byte, takes snapshot
    localparam logic [bus_addr_width-1:0] addr_cnt1     = 16'd9;
    localparam logic [bus_addr_width-1:0] addr_cnt2     = 16'd10;
    localparam logic [bus_addr_width-1:0] addr_cnt3     = 16'd11; // write loads the counter
    localparam logic [bus_addr_width-1:0] addr_lost     = 16'd12;
    localparam logic [bus_addr_width-1:0] addr_trig_sel = 16'd13;
    localparam logic [bus_addr_width-1:0] addr_veto_sel = 16'd14;
    localparam logic [bus_addr_width-1:0] addr_trig_inv = 16'd15;
    localparam logic [bus_addr_width-1:0] addr_max0     = 16'd16; // max count bytes 16..19
    localparam logic [bus_addr_width-1:0] num_regs      = 16'd20;

    localparam int conf_enable_bit = 3;

    // trigger data FIFO
    localparam int fifo_depth      = 8;
    localparam int fifo_addr_width = 3;

    // async trigger and veto pins
    localparam int sync_stages = 3;

    // trigger conditioning setup from the register bank
    typedef struct packed {
        logic       enable;      // config trigger enable
        logic [7:0] trig_select;
        logic [7:0] trig_invert;
        logic [7:0] veto_select;
    } trig_cfg_t;

    // one word per accepted trigger
    typedef struct packed {
        logic        marker; // always set
        logic [30:0] number; // counter at acceptance
    } trig_word_t;

endpackage
